// File: husky_capture.f
+incdir+rtl
+incdir+verification
rtl/husky_capture_pkg.sv
rtl/wb_if.sv
rtl/reg_bank.sv
rtl/edge_recorder.sv
rtl/la_sampler.sv
rtl/fifo_write_arbiter.sv
rtl/sample_fifo.sv
rtl/husky_capture_top.sv
verification/husky_capture_tb.sv

// File: rtl/edge_recorder.sv
`include "husky_capture_settings.svh"

module edge_recorder (
   input  logic                             clk_usb_buf,
   input  logic                             arst_n_i,
   input  logic [`HC_PIN_W-1:0]             pins_i,
   input  husky_capture_pkg::capture_ctrl_t ctrl_i,
   wb_if.master                             wb,
   output logic                             ovf_o
);
   import husky_capture_pkg::*;

   logic [`HC_PIN_W-1:0] pins_q;
   logic [`HC_PIN_W-1:0] pins_prev_q;
   logic                 change;
   logic                 take;
   logic [6:0]           seq_q;
   capture_record_t      rec_q;
   logic                 valid_q;     // One record held for the FIFO
   logic                 gap_q;       // Forces stb low after each ack

   // Previous value tracks even while disabled
   assign change = ctrl_i.rec_en & (pins_q != pins_prev_q);
   assign take   = change & (~valid_q | wb.ack);

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pins_q      <= '0;
         pins_prev_q <= '0;
         seq_q       <= '0;
         valid_q     <= 1'b0;
         gap_q       <= 1'b0;
         ovf_o       <= 1'b0;
      end else begin
         pins_q      <= pins_i;
         pins_prev_q <= pins_q;
         gap_q       <= wb.ack;
         ovf_o       <= change & ~take;   // Change lost behind a pending record
         if (take)
            valid_q <= 1'b1;
         else if (wb.ack)
            valid_q <= 1'b0;
         if (ctrl_i.clear_seq)
            seq_q <= '0;
         else if (take)
            seq_q <= seq_q + 7'd1;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (take) begin
         rec_q.tag  <= SRC_EDGE;
         rec_q.seq  <= seq_q;
         rec_q.pins <= pins_q;
      end
   end

   assign wb.cyc   = valid_q & ~gap_q;
   assign wb.stb   = valid_q & ~gap_q;
   assign wb.we    = 1'b1;
   assign wb.adr   = `HC_ADDR_W'(`HC_REG_FIFO);
   assign wb.dat_w = rec_q;

endmodule

// File: rtl/fifo_write_arbiter.sv
module fifo_write_arbiter (
   input  logic clk_usb_buf,
   input  logic arst_n_i,
   wb_if.slave  m_a,
   wb_if.slave  m_b,
   wb_if.master s
);
   import husky_capture_pkg::*;

   // Port a serves the edge recorder, port b the LA sampler
   logic req_a;
   logic req_b;
   logic locked_q;   // Grant held until ack
   src_t owner_q;
   src_t prio_q;
   src_t sel;

   assign req_a = m_a.cyc & m_a.stb;
   assign req_b = m_b.cyc & m_b.stb;

   always_comb begin
      if (locked_q)
         sel = owner_q;
      else if (req_a && req_b)
         sel = prio_q;
      else if (req_b)
         sel = SRC_LA;
      else
         sel = SRC_EDGE;
   end

   assign s.cyc   = (sel == SRC_LA) ? m_b.cyc   : m_a.cyc;
   assign s.stb   = (sel == SRC_LA) ? m_b.stb   : m_a.stb;
   assign s.we    = (sel == SRC_LA) ? m_b.we    : m_a.we;
   assign s.adr   = (sel == SRC_LA) ? m_b.adr   : m_a.adr;
   assign s.dat_w = (sel == SRC_LA) ? m_b.dat_w : m_a.dat_w;

   assign m_a.ack   = s.ack & (sel == SRC_EDGE);
   assign m_b.ack   = s.ack & (sel == SRC_LA);
   assign m_a.dat_r = s.dat_r;
   assign m_b.dat_r = s.dat_r;

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         locked_q <= 1'b0;
         owner_q  <= SRC_EDGE;
         prio_q   <= SRC_EDGE;
      end else if (s.ack) begin
         locked_q <= 1'b0;
         prio_q   <= (sel == SRC_EDGE) ? SRC_LA : SRC_EDGE;   // Other side next
      end else if (s.cyc && s.stb) begin
         locked_q <= 1'b1;
         owner_q  <= sel;
      end
   end

endmodule

// File: rtl/husky_capture_pkg.sv
`include "husky_capture_settings.svh"

package husky_capture_pkg;

   // Source of a record, also the FIFO arbiter grant
   typedef enum logic {
      SRC_EDGE = 1'b0,
      SRC_LA   = 1'b1
   } src_t;

   typedef struct packed {
      src_t                 tag;
      logic [6:0]           seq;    // Per source, wraps
      logic [`HC_PIN_W-1:0] pins;
   } capture_record_t;

   // Register bank to capture sources
   typedef struct packed {
      logic       rec_en;
      logic       la_start;         // One cycle pulse
      logic [7:0] la_div;
      logic [7:0] la_count;
      logic       clear_seq;        // One cycle pulse
   } capture_ctrl_t;

endpackage

// File: rtl/husky_capture_settings.svh
`ifndef HUSKY_CAPTURE_SETTINGS_SVH
`define HUSKY_CAPTURE_SETTINGS_SVH

// Bus widths
`define HC_PIN_W         8
`define HC_ADDR_W        8
`define HC_DATA_W        16

// Record FIFO
`define HC_FIFO_DEPTH    16
`define HC_LEVEL_W       5    // Counts 0 to HC_FIFO_DEPTH

// Register map
`define HC_REG_CTRL      0
`define HC_REG_LA_DIV    1
`define HC_REG_LA_COUNT  2
`define HC_REG_STATUS    3
`define HC_REG_FIFO      4

// CTRL bits
`define HC_CTRL_REC_EN   0
`define HC_CTRL_LA_START 1
`define HC_CTRL_CLR_SEQ  2

// STATUS bits above the FIFO level field
`define HC_STAT_EDGE_OVF 8
`define HC_STAT_LA_OVF   9
`define HC_STAT_LA_BUSY  10

`endif

// File: rtl/husky_capture_top.sv
`include "husky_capture_settings.svh"

module husky_capture_top (
   input  logic                  clk_usb_buf,
   input  logic                  arst_n_i,
   input  logic [`HC_PIN_W-1:0]  pins_i,
   input  logic                  host_cyc_i,
   input  logic                  host_stb_i,
   input  logic                  host_we_i,
   input  logic [`HC_ADDR_W-1:0] host_adr_i,
   input  logic [`HC_DATA_W-1:0] host_dat_i,
   output logic [`HC_DATA_W-1:0] host_dat_o,
   output logic                  host_ack_o
);
   import husky_capture_pkg::*;

   capture_ctrl_t          ctrl;
   capture_record_t        fifo_rdata;
   logic [`HC_LEVEL_W-1:0] fifo_level;
   logic                   fifo_pop;
   logic                   edge_ovf;
   logic                   la_ovf;
   logic                   la_busy;

   wb_if wb_edge ();   // Recorder to arbiter port a
   wb_if wb_la ();     // Sampler to arbiter port b
   wb_if wb_fifo ();

   reg_bank u_reg_bank (
      .clk_usb_buf  (clk_usb_buf),
      .arst_n_i     (arst_n_i),
      .host_cyc_i   (host_cyc_i),
      .host_stb_i   (host_stb_i),
      .host_we_i    (host_we_i),
      .host_adr_i   (host_adr_i),
      .host_dat_i   (host_dat_i),
      .host_dat_o   (host_dat_o),
      .host_ack_o   (host_ack_o),
      .ctrl_o       (ctrl),
      .fifo_pop_o   (fifo_pop),
      .fifo_rdata_i (fifo_rdata),
      .fifo_level_i (fifo_level),
      .edge_ovf_i   (edge_ovf),
      .la_ovf_i     (la_ovf),
      .la_busy_i    (la_busy)
   );

   edge_recorder u_edge_recorder (
      .clk_usb_buf (clk_usb_buf),
      .arst_n_i    (arst_n_i),
      .pins_i      (pins_i),
      .ctrl_i      (ctrl),
      .wb          (wb_edge.master),
      .ovf_o       (edge_ovf)
   );

   la_sampler u_la_sampler (
      .clk_usb_buf (clk_usb_buf),
      .arst_n_i    (arst_n_i),
      .pins_i      (pins_i),
      .ctrl_i      (ctrl),
      .wb          (wb_la.master),
      .busy_o      (la_busy),
      .ovf_o       (la_ovf)
   );

   fifo_write_arbiter u_fifo_write_arbiter (
      .clk_usb_buf (clk_usb_buf),
      .arst_n_i    (arst_n_i),
      .m_a         (wb_edge.slave),
      .m_b         (wb_la.slave),
      .s           (wb_fifo.master)
   );

   sample_fifo u_sample_fifo (
      .clk_usb_buf (clk_usb_buf),
      .arst_n_i    (arst_n_i),
      .pop_i       (fifo_pop),
      .wb          (wb_fifo.slave),
      .rdata_o     (fifo_rdata),
      .level_o     (fifo_level)
   );

endmodule

// File: rtl/la_sampler.sv
`include "husky_capture_settings.svh"

module la_sampler (
   input  logic                             clk_usb_buf,
   input  logic                             arst_n_i,
   input  logic [`HC_PIN_W-1:0]             pins_i,
   input  husky_capture_pkg::capture_ctrl_t ctrl_i,
   wb_if.master                             wb,
   output logic                             busy_o,
   output logic                             ovf_o
);
   import husky_capture_pkg::*;

   logic [`HC_PIN_W-1:0] pins_q;
   logic [7:0]           div_q;       // Interval latched at start
   logic [7:0]           tick_q;      // Cycles until next sample
   logic [7:0]           left_q;      // Samples left in this run
   logic [6:0]           idx_q;
   logic                 due;
   logic                 take;
   capture_record_t      rec_q;
   logic                 valid_q;
   logic                 gap_q;

   assign due  = busy_o & (tick_q == 8'd0);
   assign take = due & (~valid_q | wb.ack);

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pins_q  <= '0;
         div_q   <= '0;
         tick_q  <= '0;
         left_q  <= '0;
         idx_q   <= '0;
         busy_o  <= 1'b0;
         valid_q <= 1'b0;
         gap_q   <= 1'b0;
         ovf_o   <= 1'b0;
      end else begin
         pins_q <= pins_i;
         gap_q  <= wb.ack;
         ovf_o  <= due & ~take;
         if (take)
            valid_q <= 1'b1;
         else if (wb.ack)
            valid_q <= 1'b0;

         if (!busy_o) begin
            // Start while busy falls through unseen
            if (ctrl_i.la_start && ctrl_i.la_count != 8'd0) begin
               busy_o <= 1'b1;
               div_q  <= ctrl_i.la_div;
               tick_q <= ctrl_i.la_div;
               left_q <= ctrl_i.la_count;
               idx_q  <= '0;
            end
         end else if (due) begin
            tick_q <= div_q;
            left_q <= left_q - 8'd1;
            idx_q  <= idx_q + 7'd1;        // Dropped samples still advance
            busy_o <= (left_q != 8'd1);
         end else begin
            tick_q <= tick_q - 8'd1;
         end
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (take) begin
         rec_q.tag  <= SRC_LA;
         rec_q.seq  <= idx_q;
         rec_q.pins <= pins_q;
      end
   end

   assign wb.cyc   = valid_q & ~gap_q;
   assign wb.stb   = valid_q & ~gap_q;
   assign wb.we    = 1'b1;
   assign wb.adr   = `HC_ADDR_W'(`HC_REG_FIFO);
   assign wb.dat_w = rec_q;

endmodule

// File: rtl/reg_bank.sv
`include "husky_capture_settings.svh"

module reg_bank (
   input  logic                               clk_usb_buf,
   input  logic                               arst_n_i,
   input  logic                               host_cyc_i,
   input  logic                               host_stb_i,
   input  logic                               host_we_i,
   input  logic [`HC_ADDR_W-1:0]              host_adr_i,
   input  logic [`HC_DATA_W-1:0]              host_dat_i,
   output logic [`HC_DATA_W-1:0]              host_dat_o,
   output logic                               host_ack_o,
   output husky_capture_pkg::capture_ctrl_t   ctrl_o,
   output logic                               fifo_pop_o,
   input  husky_capture_pkg::capture_record_t fifo_rdata_i,
   input  logic [`HC_LEVEL_W-1:0]             fifo_level_i,
   input  logic                               edge_ovf_i,
   input  logic                               la_ovf_i,
   input  logic                               la_busy_i
);
   import husky_capture_pkg::*;

   logic                  req;         // First cycle of a host transfer
   logic                  wr_req;
   logic                  rd_req;
   logic                  fifo_nempty;
   logic                  status_wr;
   logic                  rec_en_q;
   logic                  la_start_q;
   logic                  clear_seq_q;
   logic [7:0]            la_div_q;
   logic [7:0]            la_count_q;
   logic                  edge_ovf_q;
   logic                  la_ovf_q;
   logic [`HC_DATA_W-1:0] status;
   logic [`HC_DATA_W-1:0] rd_regs;
   capture_record_t       rd_fifo;

   assign req         = host_cyc_i & host_stb_i & ~host_ack_o;
   assign wr_req      = req & host_we_i;
   assign rd_req      = req & ~host_we_i;
   assign fifo_nempty = (fifo_level_i != '0);
   assign status_wr   = wr_req & (host_adr_i == `HC_REG_STATUS);

   always_comb begin
      status                    = '0;
      status[`HC_LEVEL_W-1:0]   = fifo_level_i;
      status[`HC_STAT_EDGE_OVF] = edge_ovf_q;
      status[`HC_STAT_LA_OVF]   = la_ovf_q;
      status[`HC_STAT_LA_BUSY]  = la_busy_i;
   end

   always_comb begin
      rd_regs = '0;
      case (host_adr_i)
         `HC_REG_CTRL:     rd_regs[`HC_CTRL_REC_EN] = rec_en_q;
         `HC_REG_LA_DIV:   rd_regs[7:0] = la_div_q;
         `HC_REG_LA_COUNT: rd_regs[7:0] = la_count_q;
         `HC_REG_STATUS:   rd_regs = status;
         default:          rd_regs = '0;
      endcase
   end

   // Empty FIFO reads back as zero
   assign rd_fifo = (host_adr_i == `HC_REG_FIFO && fifo_nempty) ? fifo_rdata_i : '0;

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         host_ack_o  <= 1'b0;
         host_dat_o  <= '0;
         fifo_pop_o  <= 1'b0;
         rec_en_q    <= 1'b0;
         la_start_q  <= 1'b0;
         clear_seq_q <= 1'b0;
         la_div_q    <= '0;
         la_count_q  <= '0;
         edge_ovf_q  <= 1'b0;
         la_ovf_q    <= 1'b0;
      end else begin
         host_ack_o  <= req;
         host_dat_o  <= rd_req ? (rd_regs | rd_fifo) : '0;
         // Pop lands in the ack cycle, head was sampled above
         fifo_pop_o  <= rd_req & (host_adr_i == `HC_REG_FIFO) & fifo_nempty;
         la_start_q  <= wr_req & (host_adr_i == `HC_REG_CTRL) & host_dat_i[`HC_CTRL_LA_START];
         clear_seq_q <= wr_req & (host_adr_i == `HC_REG_CTRL) & host_dat_i[`HC_CTRL_CLR_SEQ];
         if (wr_req && host_adr_i == `HC_REG_CTRL)
            rec_en_q <= host_dat_i[`HC_CTRL_REC_EN];
         if (wr_req && host_adr_i == `HC_REG_LA_DIV)
            la_div_q <= host_dat_i[7:0];
         if (wr_req && host_adr_i == `HC_REG_LA_COUNT)
            la_count_q <= host_dat_i[7:0];

         // A new overflow wins over a clear in the same cycle
         if (edge_ovf_i)
            edge_ovf_q <= 1'b1;
         else if (status_wr)
            edge_ovf_q <= 1'b0;
         if (la_ovf_i)
            la_ovf_q <= 1'b1;
         else if (status_wr)
            la_ovf_q <= 1'b0;
      end
   end

   assign ctrl_o.rec_en    = rec_en_q;
   assign ctrl_o.la_start  = la_start_q;
   assign ctrl_o.la_div    = la_div_q;
   assign ctrl_o.la_count  = la_count_q;
   assign ctrl_o.clear_seq = clear_seq_q;

endmodule

// File: rtl/sample_fifo.sv
`include "husky_capture_settings.svh"

module sample_fifo (
   input  logic                               clk_usb_buf,
   input  logic                               arst_n_i,
   input  logic                               pop_i,
   wb_if.slave                                wb,
   output husky_capture_pkg::capture_record_t rdata_o,
   output logic [`HC_LEVEL_W-1:0]             level_o
);
   import husky_capture_pkg::*;

   localparam int PTR_W = $clog2(`HC_FIFO_DEPTH);

   capture_record_t  mem [`HC_FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic             full;
   logic             push;
   logic             pop;
   logic             ack_q;

   assign full = (level_o == `HC_LEVEL_W'(`HC_FIFO_DEPTH));
   assign push = ack_q;                        // Data still held by master
   assign pop  = pop_i & (level_o != '0);

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q    <= 1'b0;
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         level_o  <= '0;
      end else begin
         // Ack held back while full
         ack_q <= wb.cyc & wb.stb & wb.we & ~full & ~ack_q;
         if (push)
            wr_ptr_q <= wr_ptr_q + PTR_W'(1);
         if (pop)
            rd_ptr_q <= rd_ptr_q + PTR_W'(1);
         case ({push, pop})
            2'b10:   level_o <= level_o + `HC_LEVEL_W'(1);
            2'b01:   level_o <= level_o - `HC_LEVEL_W'(1);
            default: level_o <= level_o;
         endcase
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (push)
         mem[wr_ptr_q] <= wb.dat_w;
   end

   assign rdata_o  = mem[rd_ptr_q];
   assign wb.ack   = ack_q;
   assign wb.dat_r = rdata_o;

endmodule

// File: rtl/wb_if.sv
`include "husky_capture_settings.svh"

// Wishbone classic, single transfers only
interface wb_if ();
   logic                  cyc;
   logic                  stb;
   logic                  we;
   logic [`HC_ADDR_W-1:0] adr;
   logic [`HC_DATA_W-1:0] dat_w;
   logic [`HC_DATA_W-1:0] dat_r;
   logic                  ack;

   modport master (
      output cyc, stb, we, adr, dat_w,
      input  dat_r, ack
   );

   modport slave (
      input  cyc, stb, we, adr, dat_w,
      output dat_r, ack
   );
endinterface

// File: verification/husky_capture_tests.svh
`ifndef HUSKY_CAPTURE_TESTS_SVH
`define HUSKY_CAPTURE_TESTS_SVH

   // Test 1
   task automatic test_reset_state();
      logic [`HC_DATA_W-1:0] word;
      test_name = "reset_state";
      wb_read(`HC_REG_STATUS, word);
      check_status("status", 16'h0000, word);
      wb_read(`HC_REG_FIFO, word);
      check_record("empty FIFO read", '0, capture_record_t'(word));
   endtask

   // Test 2
   task automatic test_reg_readback();
      logic [`HC_DATA_W-1:0] word;
      logic [7:0]            div_v;
      logic [7:0]            cnt_v;
      test_name = "reg_readback";
      div_v = rand_byte();
      cnt_v = rand_byte();
      wb_write(`HC_REG_LA_DIV, {8'h00, div_v});
      wb_write(`HC_REG_LA_COUNT, {8'h00, cnt_v});
      wb_read(`HC_REG_LA_DIV, word);
      check_status("la_div", {8'h00, div_v}, word);
      wb_read(`HC_REG_LA_COUNT, word);
      check_status("la_count", {8'h00, cnt_v}, word);
   endtask

   // Test 3 applies ten distinct values held 4 cycles each
   task automatic test_edge_recording();
      logic [`HC_PIN_W-1:0] v;
      test_name = "edge_recording";
      wb_write(`HC_REG_CTRL, 16'h0005);   // rec_en with sequence clear
      for (int i = 0; i < 10; i++) begin
         v = next_pins();
         pins_i = v;
         exp_edge.push_back(expect_record(SRC_EDGE, 7'(i), v));
         wait_cycles(4);
      end
      wait_level(10);
      drain_and_compare(10);
   endtask

   // Test 4 runs the sampler twice with 5 samples and fixed pins per run
   task automatic test_la_sampling();
      logic [`HC_DATA_W-1:0] word;
      logic [`HC_PIN_W-1:0]  v;
      test_name = "la_sampling";
      wb_write(`HC_REG_CTRL, 16'h0000);   // Recorder off
      wb_write(`HC_REG_LA_DIV, 16'd3);
      wb_write(`HC_REG_LA_COUNT, 16'd5);
      for (int run = 0; run < 2; run++) begin
         v = next_pins();
         pins_i = v;
         wait_cycles(2);
         for (int k = 0; k < 5; k++)
            exp_la.push_back(expect_record(SRC_LA, 7'(k), v));
         wb_write(`HC_REG_CTRL, 16'h0002);
         wait_level(5);
         wb_read(`HC_REG_STATUS, word);
         check_status("status after run", 16'h0005, word);   // Busy and flags clear
         drain_and_compare(5);
      end
   endtask

   // Test 5
   task automatic test_both_sources();
      logic [`HC_DATA_W-1:0] st;
      logic [`HC_PIN_W-1:0]  v;
      test_name = "both_sources";
      la_loose  = 1'b1;
      la_next   = '0;
      pin_hist.delete();
      pin_hist.push_back(pins_i);
      wb_write(`HC_REG_LA_DIV, 16'd2);
      wb_write(`HC_REG_LA_COUNT, 16'd5);
      wb_write(`HC_REG_CTRL, 16'h0007);   // Recorder on, count cleared, LA run
      for (int i = 0; i < 5; i++) begin
         v = next_pins();
         pins_i = v;
         pin_hist.push_back(v);
         exp_edge.push_back(expect_record(SRC_EDGE, 7'(i), v));
         wait_cycles(6);
      end
      wait_settled(st);
      // Edge overflow is bit 8
      check_status("edge overflow", 16'h0000, st & 16'h0100);
      la_gaps_ok = st[`HC_STAT_LA_OVF];
      drain_and_compare(int'(st[`HC_LEVEL_W-1:0]));
      if (!la_gaps_ok)
         check_status("LA record count", 16'd5, 16'(la_next));
      la_loose = 1'b0;
   endtask

   // Test 6 fills the FIFO until the recorder loses changes
   task automatic test_overflow();
      logic [`HC_DATA_W-1:0] st;
      logic [`HC_PIN_W-1:0]  v;
      test_name = "overflow";
      wb_write(`HC_REG_STATUS, 16'h0000);   // Drops flags left by the mixed run
      wb_write(`HC_REG_CTRL, 16'h0005);
      for (int i = 0; i < 20; i++) begin
         v = next_pins();
         pins_i = v;
         // One record past the FIFO depth waits in the recorder
         if (i <= `HC_FIFO_DEPTH)
            exp_edge.push_back(expect_record(SRC_EDGE, 7'(i), v));
         wait_cycles(4);
      end
      wb_read(`HC_REG_STATUS, st);
      check_status("status when full", 16'h0110, st);
      wb_write(`HC_REG_STATUS, 16'h0000);
      wb_read(`HC_REG_STATUS, st);
      check_status("status after clear", 16'h0010, st);
      drain_and_compare(`HC_FIFO_DEPTH + 1);
   endtask

`endif

// File: verification/husky_capture_tb.sv
`include "husky_capture_settings.svh"

module husky_capture_tb;
   import husky_capture_pkg::*;

   localparam int BUS_TIMEOUT  = 16;
   localparam int POLL_TIMEOUT = 100;

   logic                  clk_usb_buf;
   logic                  arst_n_i;
   logic [`HC_PIN_W-1:0]  pins_i;
   logic                  host_cyc_i;
   logic                  host_stb_i;
   logic                  host_we_i;
   logic [`HC_ADDR_W-1:0] host_adr_i;
   logic [`HC_DATA_W-1:0] host_dat_i;
   logic [`HC_DATA_W-1:0] host_dat_o;
   logic                  host_ack_o;

   logic [31:0]           lcg_state;
   string                 test_name;
   capture_record_t       exp_edge [$];
   capture_record_t       exp_la [$];
   logic [`HC_PIN_W-1:0]  pin_hist [$];   // Values driven during a mixed run
   logic                  la_loose;       // LA sample times not modelled
   logic                  la_gaps_ok;
   logic [6:0]            la_next;

   husky_capture_top dut (
      .clk_usb_buf (clk_usb_buf),
      .arst_n_i    (arst_n_i),
      .pins_i      (pins_i),
      .host_cyc_i  (host_cyc_i),
      .host_stb_i  (host_stb_i),
      .host_we_i   (host_we_i),
      .host_adr_i  (host_adr_i),
      .host_dat_i  (host_dat_i),
      .host_dat_o  (host_dat_o),
      .host_ack_o  (host_ack_o)
   );

   initial begin
      clk_usb_buf = 1'b0;
      forever #4 clk_usb_buf = ~clk_usb_buf;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [7:0] rand_byte();
      lcg_state = lcg_next(lcg_state);
      return lcg_state[23:16];   // Upper bits, better spread
   endfunction

   // New pin value, never equal to the one on the pins now
   function automatic logic [`HC_PIN_W-1:0] next_pins();
      logic [`HC_PIN_W-1:0] v;
      v = rand_byte();
      if (v == pins_i)
         v = v ^ 8'h01;
      return v;
   endfunction

   function automatic capture_record_t expect_record(input src_t tag, input logic [6:0] seq,
                                                     input logic [`HC_PIN_W-1:0] pins);
      capture_record_t r;
      r.tag  = tag;
      r.seq  = seq;
      r.pins = pins;
      return r;
   endfunction

   function automatic logic pins_applied(input logic [`HC_PIN_W-1:0] v);
      foreach (pin_hist[i])
         if (pin_hist[i] == v)
            return 1'b1;
      return 1'b0;
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_record(input string what, input capture_record_t exp,
                               input capture_record_t got);
      if (got !== exp)
         report_failure($sformatf("MISMATCH %s %s: expected %h actual %h",
                                  test_name, what, exp, got));
   endtask

   task automatic check_status(input string what, input logic [`HC_DATA_W-1:0] exp,
                               input logic [`HC_DATA_W-1:0] got);
      if (got !== exp)
         report_failure($sformatf("MISMATCH %s %s: expected %h actual %h",
                                  test_name, what, exp, got));
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) begin
         @(posedge clk_usb_buf);
         #1;
      end
   endtask

   // One Wishbone classic transfer, stb dropped after ack
   task automatic bus_cycle(input logic we, input logic [`HC_ADDR_W-1:0] adr,
                            input logic [`HC_DATA_W-1:0] wdat,
                            output logic [`HC_DATA_W-1:0] rdat);
      int n;
      host_cyc_i = 1'b1;
      host_stb_i = 1'b1;
      host_we_i  = we;
      host_adr_i = adr;
      host_dat_i = wdat;
      n = 0;
      do begin
         @(posedge clk_usb_buf);
         #1;
         n++;
      end while (!host_ack_o && n < BUS_TIMEOUT);
      if (!host_ack_o)
         report_failure("Timeout waiting for ack on the register bus");
      rdat       = host_dat_o;
      host_cyc_i = 1'b0;
      host_stb_i = 1'b0;
      host_we_i  = 1'b0;
      wait_cycles(1);   // Idle cycle between transfers
   endtask

   task automatic wb_write(input logic [`HC_ADDR_W-1:0] adr, input logic [`HC_DATA_W-1:0] dat);
      logic [`HC_DATA_W-1:0] discard;
      bus_cycle(1'b1, adr, dat, discard);
   endtask

   task automatic wb_read(input logic [`HC_ADDR_W-1:0] adr, output logic [`HC_DATA_W-1:0] dat);
      bus_cycle(1'b0, adr, '0, dat);
   endtask

   task automatic wait_level(input int level);
      logic [`HC_DATA_W-1:0] st;
      int n;
      n = 0;
      do begin
         wb_read(`HC_REG_STATUS, st);
         n++;
      end while (st[`HC_LEVEL_W-1:0] != level && n < POLL_TIMEOUT);
      if (st[`HC_LEVEL_W-1:0] != level)
         report_failure("Timeout: FIFO level never reached the expected count");
   endtask

   // Sampler done and FIFO level no longer moving
   task automatic wait_settled(output logic [`HC_DATA_W-1:0] st);
      logic [`HC_DATA_W-1:0] prev;
      int n;
      n = 0;
      wb_read(`HC_REG_STATUS, st);
      do begin
         prev = st;
         wb_read(`HC_REG_STATUS, st);
         n++;
      end while ((st[`HC_STAT_LA_BUSY] || st[`HC_LEVEL_W-1:0] != prev[`HC_LEVEL_W-1:0])
                 && n < POLL_TIMEOUT);
      if (st[`HC_STAT_LA_BUSY] || st[`HC_LEVEL_W-1:0] != prev[`HC_LEVEL_W-1:0])
         report_failure("Timeout: capture never settled after the mixed run");
   endtask

   // Pops records and matches each against the queue of its own source
   task automatic drain_and_compare(input int count);
      logic [`HC_DATA_W-1:0] word;
      capture_record_t       got;
      for (int i = 0; i < count; i++) begin
         wb_read(`HC_REG_FIFO, word);
         got = capture_record_t'(word);
         if (got.tag == SRC_EDGE) begin
            if (exp_edge.size() == 0)
               report_failure("Edge record read from the FIFO while none was expected");
            check_record($sformatf("edge record %0d", i), exp_edge.pop_front(), got);
         end else if (la_loose) begin
            if (!pins_applied(got.pins))
               report_failure("LA record holds a pin value that was never driven");
            if (la_gaps_ok && got.seq > la_next)
               la_next = got.seq;   // Samples dropped on overflow
            check_record($sformatf("LA record %0d", i),
                         expect_record(SRC_LA, la_next, got.pins), got);
            la_next++;
         end else begin
            if (exp_la.size() == 0)
               report_failure("LA record read from the FIFO while none was expected");
            check_record($sformatf("LA record %0d", i), exp_la.pop_front(), got);
         end
      end
      if (exp_edge.size() != 0 || exp_la.size() != 0)
         report_failure("FIFO held fewer records than expected");
   endtask

`include "husky_capture_tests.svh"

   initial begin
      lcg_state  = 32'hf576;
      test_name  = "init";
      la_loose   = 1'b0;
      la_gaps_ok = 1'b0;
      la_next    = '0;
      arst_n_i   = 1'b0;
      pins_i     = '0;
      host_cyc_i = 1'b0;
      host_stb_i = 1'b0;
      host_we_i  = 1'b0;
      host_adr_i = '0;
      host_dat_i = '0;
      repeat (8) @(posedge clk_usb_buf);
      #1;
      arst_n_i = 1'b1;
      wait_cycles(2);
      test_reset_state();
      test_reg_readback();
      test_edge_recording();
      test_la_sampling();
      test_both_sources();
      test_overflow();
      $display("Result: PASSED");
      $finish;
   end

endmodule
